// ==== rtl/issue_cfg.svh ====
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// issue queue geometry
`define ISSUE_QUEUE_DEPTH 16

// head/tail pointer width, log2 of the depth
`define ISSUE_IDX_W 4

// architectural register number
`define REG_ADDR_W 5

// data word, also used for pc and immediate
`define DATA_W 32

`endif

// ==== rtl/issue_pkg.sv ====
`default_nettype none

`include "issue_cfg.svh"

package issue_pkg;

    // coarse operation class, enough for the pairing rules
    typedef enum logic [3:0] {
        op_alu    = 4'd0,
        op_mult   = 4'd1,
        op_div    = 4'd2,
        op_load   = 4'd3,
        op_store  = 4'd4,
        op_branch = 4'd5,
        op_jump   = 4'd6,
        op_mtc0   = 4'd7,
        op_mfc0   = 4'd8
    } op_t;

    // one decoded instruction as held in the issue queue
    typedef struct packed {
        logic                   valid;
        logic [`DATA_W-1:0]     pc;
        op_t                    op;
        // destination and its write enable
        logic [`REG_ADDR_W-1:0] rdst;
        logic                   regwrite;
        // source register numbers
        logic [`REG_ADDR_W-1:0] ra1;
        logic [`REG_ADDR_W-1:0] ra2;
        // register file values read at decode
        logic [`DATA_W-1:0]     rd1;
        logic [`DATA_W-1:0]     rd2;
        logic [`DATA_W-1:0]     imm;
        // branch delay slot
        logic                   is_slot;
    } issue_entry_t;

endpackage

`default_nettype wire

// ==== rtl/operand_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_cfg.svh"

module operand_bypass (
    input  wire logic [`REG_ADDR_W-1:0]      ra1,
    input  wire logic [`REG_ADDR_W-1:0]      ra2,
    input  wire logic [`DATA_W-1:0]          rd1,
    input  wire logic [`DATA_W-1:0]          rd2,
    // index 1 is execute, index 0 is memory
    input  wire logic [1:0]                  fwd_valid,
    input  wire logic [1:0][`REG_ADDR_W-1:0] fwd_reg,
    input  wire logic [1:0]                  fwd_ready,
    input  wire logic [1:0][`DATA_W-1:0]     fwd_data,
    output logic [`DATA_W-1:0]               op1,
    output logic [`DATA_W-1:0]               op2,
    output logic                             src_ready
);

    // both sources handled by the same loop, index 0 is ra1
    logic [1:0][`REG_ADDR_W-1:0] ra;
    logic [1:0][`DATA_W-1:0]     rd;
    logic [1:0][`DATA_W-1:0]     res;
    logic [1:0]                  rdy;
    logic [1:0]                  hit_ex;
    logic [1:0]                  hit_mem;

    assign ra = {ra2, ra1};
    assign rd = {rd2, rd1};

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            hit_ex[s]  = fwd_valid[1] && (fwd_reg[1] == ra[s]);
            hit_mem[s] = fwd_valid[0] && (fwd_reg[0] == ra[s]);
            rdy[s]     = 1'b1;
            res[s]     = rd[s];
            // $0 never forwards
            if (ra[s] != '0) begin
                if (hit_ex[s]) begin
                    rdy[s] = fwd_ready[1];
                    res[s] = fwd_ready[1] ? fwd_data[1] : rd[s];
                end else if (hit_mem[s]) begin
                    rdy[s] = fwd_ready[0];
                    res[s] = fwd_ready[0] ? fwd_data[0] : rd[s];
                end
            end
        end
    end

    assign op1       = res[0];
    assign op2       = res[1];
    assign src_ready = &rdy;

    // producers never write $0 from both stages at once
    zero_claim_a: assert final (!(fwd_valid[1] && (fwd_reg[1] == '0) &&
                                  fwd_valid[0] && (fwd_reg[0] == '0)))
        else $error("both forwarding ports claim register zero");

endmodule

`default_nettype wire

// ==== rtl/pair_check.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_cfg.svh"

module pair_check (
    input  wire logic [1:0]                  cand_valid,
    input  wire issue_pkg::op_t [1:0]        cand_op,
    input  wire logic [1:0][`REG_ADDR_W-1:0] cand_rdst,
    input  wire logic [1:0]                  cand_regwrite,
    input  wire logic [1:0][`REG_ADDR_W-1:0] cand_ra1,
    input  wire logic [1:0][`REG_ADDR_W-1:0] cand_ra2,
    input  wire logic [1:0]                  cand_is_slot,
    input  wire logic [1:0]                  src_ready,
    output logic [1:0]                       issue_en
);

    // only one multiply/divide unit
    function automatic logic is_muldiv(input issue_pkg::op_t op);
        return (op == issue_pkg::op_mult) || (op == issue_pkg::op_div);
    endfunction

    function automatic logic is_ctrl(input issue_pkg::op_t op);
        return (op == issue_pkg::op_branch) || (op == issue_pkg::op_jump);
    endfunction

    logic raw_hazard;
    logic muldiv_hazard;
    logic cp0_hazard;
    logic ctrl_hazard;
    logic any_hazard;

    // younger reads what the older writes, $0 excluded
    assign raw_hazard = cand_regwrite[1] && (cand_rdst[1] != '0) &&
                        ((cand_rdst[1] == cand_ra1[0]) || (cand_rdst[1] == cand_ra2[0]));

    assign muldiv_hazard = is_muldiv(cand_op[1]) && is_muldiv(cand_op[0]);

    // a single CP0 write port
    assign cp0_hazard = (cand_op[1] == issue_pkg::op_mtc0) &&
                        (cand_op[0] == issue_pkg::op_mtc0);

    // a younger branch or jump must lead its own pair with its delay slot
    assign ctrl_hazard = is_ctrl(cand_op[0]);

    assign any_hazard = raw_hazard | muldiv_hazard | cp0_hazard | ctrl_hazard;

    always_comb begin
        issue_en[1] = cand_valid[1] && src_ready[1];
        issue_en[0] = issue_en[1] && cand_valid[0] && src_ready[0];
        // delay slot always goes with its branch
        if (!cand_is_slot[0] && any_hazard) begin
            issue_en[0] = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_cfg.svh"

module issue_queue (
    input  wire logic                             clk,
    input  wire logic                             arst_n,
    input  wire logic                             flush,
    input  wire logic [1:0]                       dec_valid,
    input  wire logic [1:0][`DATA_W-1:0]          dec_pc,
    input  wire issue_pkg::op_t [1:0]             dec_op,
    input  wire logic [1:0][`REG_ADDR_W-1:0]      dec_rdst,
    input  wire logic [1:0]                       dec_regwrite,
    input  wire logic [1:0][`REG_ADDR_W-1:0]      dec_ra1,
    input  wire logic [1:0][`REG_ADDR_W-1:0]      dec_ra2,
    input  wire logic [1:0][`DATA_W-1:0]          dec_rd1,
    input  wire logic [1:0][`DATA_W-1:0]          dec_rd2,
    input  wire logic [1:0][`DATA_W-1:0]          dec_imm,
    input  wire logic [1:0]                       dec_is_slot,
    input  wire logic [1:0]                       issue_en,
    output logic                                  queue_full,
    output logic [1:0]                            cand_valid,
    output logic [1:0][`DATA_W-1:0]               cand_pc,
    output issue_pkg::op_t [1:0]                  cand_op,
    output logic [1:0][`REG_ADDR_W-1:0]           cand_rdst,
    output logic [1:0]                            cand_regwrite,
    output logic [1:0][`REG_ADDR_W-1:0]           cand_ra1,
    output logic [1:0][`REG_ADDR_W-1:0]           cand_ra2,
    output logic [1:0][`DATA_W-1:0]               cand_rd1,
    output logic [1:0][`DATA_W-1:0]               cand_rd2,
    output logic [1:0][`DATA_W-1:0]               cand_imm,
    output logic [1:0]                            cand_is_slot
);

    localparam int IDX_W = `ISSUE_IDX_W;
    localparam int CNT_W = `ISSUE_IDX_W + 1;

    issue_pkg::issue_entry_t mem [`ISSUE_QUEUE_DEPTH];

    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [IDX_W-1:0] head_nxt;
    logic [IDX_W-1:0] wr_idx0;
    logic [CNT_W-1:0] count;

    logic [1:0] dec_acc;
    issue_pkg::issue_entry_t dec_entry [1:0];
    issue_pkg::issue_entry_t cand [1:0];

    // issued totals, split into queue part and decode part
    logic [1:0] n_iss;
    logic [1:0] n_q_iss;
    logic [1:0] d_iss;
    logic       enq1;
    logic       enq0;
    logic [1:0] n_enq;

    // two free slots needed to take a full pair
    assign queue_full = count >= CNT_W'(`ISSUE_QUEUE_DEPTH - 1);
    assign dec_acc    = dec_valid & {2{~queue_full}};
    assign head_nxt   = head + IDX_W'(1);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dec_entry[i].valid    = dec_acc[i];
            dec_entry[i].pc       = dec_pc[i];
            dec_entry[i].op       = dec_op[i];
            dec_entry[i].rdst     = dec_rdst[i];
            dec_entry[i].regwrite = dec_regwrite[i];
            dec_entry[i].ra1      = dec_ra1[i];
            dec_entry[i].ra2      = dec_ra2[i];
            dec_entry[i].rd1      = dec_rd1[i];
            dec_entry[i].rd2      = dec_rd2[i];
            dec_entry[i].imm      = dec_imm[i];
            dec_entry[i].is_slot  = dec_is_slot[i];
        end
    end

    // queue contents first, then the decode pair, in program order
    always_comb begin
        cand[1] = dec_entry[1];
        cand[0] = dec_entry[0];
        if (count >= CNT_W'(2)) begin
            cand[1] = mem[head];
            cand[0] = mem[head_nxt];
        end else if (count == CNT_W'(1)) begin
            cand[1] = mem[head];
            cand[0] = dec_entry[1];
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            cand_valid[i]    = cand[i].valid;
            cand_pc[i]       = cand[i].pc;
            cand_op[i]       = cand[i].op;
            cand_rdst[i]     = cand[i].rdst;
            cand_regwrite[i] = cand[i].regwrite;
            cand_ra1[i]      = cand[i].ra1;
            cand_ra2[i]      = cand[i].ra2;
            cand_rd1[i]      = cand[i].rd1;
            cand_rd2[i]      = cand[i].rd2;
            cand_imm[i]      = cand[i].imm;
            cand_is_slot[i]  = cand[i].is_slot;
        end
    end

    assign n_iss   = {1'b0, issue_en[1]} + {1'b0, issue_en[0]};
    // queue entries go first, anything beyond count came from decode
    assign n_q_iss = (count >= CNT_W'(n_iss)) ? n_iss : count[1:0];
    assign d_iss   = n_iss - n_q_iss;

    // slot 1 is consumed before slot 0
    assign enq1    = dec_acc[1] && (d_iss == 2'd0);
    assign enq0    = dec_acc[0] && (d_iss != 2'd2);
    assign n_enq   = {1'b0, enq1} + {1'b0, enq0};
    assign wr_idx0 = tail + IDX_W'(enq1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= tail;
            count <= '0;
        end else begin
            head  <= head + IDX_W'(n_q_iss);
            tail  <= tail + IDX_W'(n_enq);
            count <= count - CNT_W'(n_q_iss) + CNT_W'(n_enq);
        end
    end

    // decode input in the flush cycle is dropped
    always_ff @(posedge clk) begin
        if (!flush) begin
            if (enq1) begin
                mem[tail] <= dec_entry[1];
            end
            if (enq0) begin
                mem[wr_idx0] <= dec_entry[0];
            end
        end
    end

    // decode must hold off while fewer than two entries are free
    no_enq_full_a: assert property (@(posedge clk) disable iff (!arst_n)
        queue_full |-> (dec_valid == 2'b00))
        else $error("decode presented a valid slot while the queue was full");

    // younger slot never issues ahead of the older one
    issue_order_a: assert property (@(posedge clk) disable iff (!arst_n)
        issue_en[0] |-> issue_en[1])
        else $error("issue_en[0] without issue_en[1]");

endmodule

`default_nettype wire

// ==== rtl/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_cfg.svh"

module issue_stage (
    input  wire logic                        clk,
    input  wire logic                        arst_n,
    input  wire logic                        flush,
    // decode pair, slot 1 older
    input  wire logic [1:0]                  dec_valid,
    input  wire logic [1:0][`DATA_W-1:0]     dec_pc,
    input  wire issue_pkg::op_t [1:0]        dec_op,
    input  wire logic [1:0][`REG_ADDR_W-1:0] dec_rdst,
    input  wire logic [1:0]                  dec_regwrite,
    input  wire logic [1:0][`REG_ADDR_W-1:0] dec_ra1,
    input  wire logic [1:0][`REG_ADDR_W-1:0] dec_ra2,
    input  wire logic [1:0][`DATA_W-1:0]     dec_rd1,
    input  wire logic [1:0][`DATA_W-1:0]     dec_rd2,
    input  wire logic [1:0][`DATA_W-1:0]     dec_imm,
    input  wire logic [1:0]                  dec_is_slot,
    // forwarding producers, 1 execute and 0 memory
    input  wire logic [1:0]                  fwd_valid,
    input  wire logic [1:0][`REG_ADDR_W-1:0] fwd_reg,
    input  wire logic [1:0]                  fwd_ready,
    input  wire logic [1:0][`DATA_W-1:0]     fwd_data,
    output logic                             queue_full,
    // issued pair
    output logic [1:0]                       iss_valid,
    output logic [1:0][`DATA_W-1:0]          iss_pc,
    output issue_pkg::op_t [1:0]             iss_op,
    output logic [1:0][`REG_ADDR_W-1:0]      iss_rdst,
    output logic [1:0]                       iss_regwrite,
    output logic [1:0][`DATA_W-1:0]          iss_rd1,
    output logic [1:0][`DATA_W-1:0]          iss_rd2,
    output logic [1:0][`DATA_W-1:0]          iss_imm,
    output logic [1:0]                       iss_is_slot
);

    logic [1:0]                  cand_valid;
    logic [1:0][`DATA_W-1:0]     cand_pc;
    issue_pkg::op_t [1:0]        cand_op;
    logic [1:0][`REG_ADDR_W-1:0] cand_rdst;
    logic [1:0]                  cand_regwrite;
    logic [1:0][`REG_ADDR_W-1:0] cand_ra1;
    logic [1:0][`REG_ADDR_W-1:0] cand_ra2;
    logic [1:0][`DATA_W-1:0]     cand_rd1;
    logic [1:0][`DATA_W-1:0]     cand_rd2;
    logic [1:0][`DATA_W-1:0]     cand_imm;
    logic [1:0]                  cand_is_slot;

    logic [1:0][`DATA_W-1:0]     res_op1;
    logic [1:0][`DATA_W-1:0]     res_op2;
    logic [1:0]                  src_ready;
    logic [1:0]                  issue_en;

    issue_queue u_queue (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .dec_valid     (dec_valid),
        .dec_pc        (dec_pc),
        .dec_op        (dec_op),
        .dec_rdst      (dec_rdst),
        .dec_regwrite  (dec_regwrite),
        .dec_ra1       (dec_ra1),
        .dec_ra2       (dec_ra2),
        .dec_rd1       (dec_rd1),
        .dec_rd2       (dec_rd2),
        .dec_imm       (dec_imm),
        .dec_is_slot   (dec_is_slot),
        .issue_en      (issue_en),
        .queue_full    (queue_full),
        .cand_valid    (cand_valid),
        .cand_pc       (cand_pc),
        .cand_op       (cand_op),
        .cand_rdst     (cand_rdst),
        .cand_regwrite (cand_regwrite),
        .cand_ra1      (cand_ra1),
        .cand_ra2      (cand_ra2),
        .cand_rd1      (cand_rd1),
        .cand_rd2      (cand_rd2),
        .cand_imm      (cand_imm),
        .cand_is_slot  (cand_is_slot)
    );

    // one resolver per candidate slot
    for (genvar s = 0; s < 2; s++) begin : g_bypass
        operand_bypass u_bypass (
            .ra1       (cand_ra1[s]),
            .ra2       (cand_ra2[s]),
            .rd1       (cand_rd1[s]),
            .rd2       (cand_rd2[s]),
            .fwd_valid (fwd_valid),
            .fwd_reg   (fwd_reg),
            .fwd_ready (fwd_ready),
            .fwd_data  (fwd_data),
            .op1       (res_op1[s]),
            .op2       (res_op2[s]),
            .src_ready (src_ready[s])
        );
    end

    pair_check u_pair (
        .cand_valid    (cand_valid),
        .cand_op       (cand_op),
        .cand_rdst     (cand_rdst),
        .cand_regwrite (cand_regwrite),
        .cand_ra1      (cand_ra1),
        .cand_ra2      (cand_ra2),
        .cand_is_slot  (cand_is_slot),
        .src_ready     (src_ready),
        .issue_en      (issue_en)
    );

    // nothing leaves in the flush cycle
    assign iss_valid    = issue_en & {2{~flush}};
    assign iss_pc       = cand_pc;
    assign iss_op       = cand_op;
    assign iss_rdst     = cand_rdst;
    assign iss_regwrite = cand_regwrite;
    assign iss_rd1      = res_op1;
    assign iss_rd2      = res_op2;
    assign iss_imm      = cand_imm;
    assign iss_is_slot  = cand_is_slot;

endmodule

`default_nettype wire

// ==== bench/issue_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_cfg.svh"

module issue_stage_tb;

    localparam int TMO = 200;

    logic                        clk;
    logic                        arst_n;
    logic                        flush;
    logic [1:0]                  dec_valid;
    logic [1:0][`DATA_W-1:0]     dec_pc;
    issue_pkg::op_t [1:0]        dec_op;
    logic [1:0][`REG_ADDR_W-1:0] dec_rdst;
    logic [1:0]                  dec_regwrite;
    logic [1:0][`REG_ADDR_W-1:0] dec_ra1;
    logic [1:0][`REG_ADDR_W-1:0] dec_ra2;
    logic [1:0][`DATA_W-1:0]     dec_rd1;
    logic [1:0][`DATA_W-1:0]     dec_rd2;
    logic [1:0][`DATA_W-1:0]     dec_imm;
    logic [1:0]                  dec_is_slot;
    logic [1:0]                  fwd_valid;
    logic [1:0][`REG_ADDR_W-1:0] fwd_reg;
    logic [1:0]                  fwd_ready;
    logic [1:0][`DATA_W-1:0]     fwd_data;
    logic                        queue_full;
    logic [1:0]                  iss_valid;
    logic [1:0][`DATA_W-1:0]     iss_pc;
    issue_pkg::op_t [1:0]        iss_op;
    logic [1:0][`REG_ADDR_W-1:0] iss_rdst;
    logic [1:0]                  iss_regwrite;
    logic [1:0][`DATA_W-1:0]     iss_rd1;
    logic [1:0][`DATA_W-1:0]     iss_rd2;
    logic [1:0][`DATA_W-1:0]     iss_imm;
    logic [1:0]                  iss_is_slot;

    // reference queue in program order, front is the oldest
    issue_pkg::issue_entry_t model_q[$];
    // expected outputs for the coming rising edge
    logic [1:0]                  exp_valid;
    logic [1:0][`DATA_W-1:0]     exp_pc;
    logic [1:0][`DATA_W-1:0]     exp_rd1;
    logic [1:0][`DATA_W-1:0]     exp_rd2;
    issue_pkg::op_t [1:0]        exp_op;
    logic [1:0][`REG_ADDR_W-1:0] exp_rdst;
    logic [1:0]                  exp_regwrite;
    logic [1:0][`DATA_W-1:0]     exp_imm;
    logic [1:0]                  exp_is_slot;
    logic                        exp_full;
    logic [1:0]                  exp_acc;
    logic [1:0]                  seen_iss;
    logic                        full_seen;
    logic [`DATA_W-1:0]          next_pc;
    int                          seed;

    issue_stage dut_i (.*);

    always #4 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    valid_a: assert property (@(posedge clk) disable iff (!arst_n) iss_valid == exp_valid)
        else fail_run($sformatf("ERR iss_valid got %h exp %h",
                                $sampled(iss_valid), $sampled(exp_valid)));

    full_a: assert property (@(posedge clk) disable iff (!arst_n) queue_full == exp_full)
        else fail_run($sformatf("ERR queue_full got %h exp %h",
                                $sampled(queue_full), $sampled(exp_full)));

    for (genvar s = 0; s < 2; s++) begin : g_slot_chk
        pc_a: assert property (@(posedge clk) disable iff (!arst_n)
            iss_valid[s] |-> (iss_pc[s] == exp_pc[s]))
            else fail_run($sformatf("ERR iss_pc[%0d] got %h exp %h", s,
                                    $sampled(iss_pc[s]), $sampled(exp_pc[s])));
        operand_a: assert property (@(posedge clk) disable iff (!arst_n)
            iss_valid[s] |-> (iss_rd1[s] == exp_rd1[s] && iss_rd2[s] == exp_rd2[s]))
            else fail_run($sformatf("ERR iss_rd1/iss_rd2[%0d] got %h %h exp %h %h", s,
                                    $sampled(iss_rd1[s]), $sampled(iss_rd2[s]),
                                    $sampled(exp_rd1[s]), $sampled(exp_rd2[s])));
        op_a: assert property (@(posedge clk) disable iff (!arst_n)
            iss_valid[s] |-> (iss_op[s] == exp_op[s]))
            else fail_run($sformatf("ERR iss_op[%0d] got %h exp %h", s,
                                    $sampled(iss_op[s]), $sampled(exp_op[s])));
        rdst_a: assert property (@(posedge clk) disable iff (!arst_n)
            iss_valid[s] |-> (iss_rdst[s] == exp_rdst[s]))
            else fail_run($sformatf("ERR iss_rdst[%0d] got %h exp %h", s,
                                    $sampled(iss_rdst[s]), $sampled(exp_rdst[s])));
        regwrite_a: assert property (@(posedge clk) disable iff (!arst_n)
            iss_valid[s] |-> (iss_regwrite[s] == exp_regwrite[s]))
            else fail_run($sformatf("ERR iss_regwrite[%0d] got %h exp %h", s,
                                    $sampled(iss_regwrite[s]), $sampled(exp_regwrite[s])));
        imm_a: assert property (@(posedge clk) disable iff (!arst_n)
            iss_valid[s] |-> (iss_imm[s] == exp_imm[s]))
            else fail_run($sformatf("ERR iss_imm[%0d] got %h exp %h", s,
                                    $sampled(iss_imm[s]), $sampled(exp_imm[s])));
        is_slot_a: assert property (@(posedge clk) disable iff (!arst_n)
            iss_valid[s] |-> (iss_is_slot[s] == exp_is_slot[s]))
            else fail_run($sformatf("ERR iss_is_slot[%0d] got %h exp %h", s,
                                    $sampled(iss_is_slot[s]), $sampled(exp_is_slot[s])));
    end

    // ready flag above the operand value
    function automatic logic [`DATA_W:0] resolve(input logic [`REG_ADDR_W-1:0] ra,
                                                 input logic [`DATA_W-1:0]     rd);
        if (ra == '0) begin
            return {1'b1, rd};
        end
        // execute is looked at before memory
        for (int p = 1; p >= 0; p--) begin
            if (fwd_valid[p] && fwd_reg[p] == ra) begin
                return {fwd_ready[p], fwd_ready[p] ? fwd_data[p] : rd};
            end
        end
        return {1'b1, rd};
    endfunction

    function automatic logic uses_muldiv_unit(input issue_pkg::op_t op);
        return op inside {issue_pkg::op_mult, issue_pkg::op_div};
    endfunction

    function automatic issue_pkg::issue_entry_t make_entry(input int s);
        issue_pkg::issue_entry_t e;
        e.valid    = 1'b1;
        e.pc       = dec_pc[s];
        e.op       = dec_op[s];
        e.rdst     = dec_rdst[s];
        e.regwrite = dec_regwrite[s];
        e.ra1      = dec_ra1[s];
        e.ra2      = dec_ra2[s];
        e.rd1      = dec_rd1[s];
        e.rd2      = dec_rd2[s];
        e.imm      = dec_imm[s];
        e.is_slot  = dec_is_slot[s];
        return e;
    endfunction

    task automatic compute_expected();
        issue_pkg::issue_entry_t pick [2];
        logic [`DATA_W:0]        a;
        logic [`DATA_W:0]        b;
        logic [1:0]              rdy;
        logic                    hazard;
        logic                    en1;
        logic                    en0;
        int                      k;
        pick[0]   = '0;
        pick[1]   = '0;
        exp_full  = model_q.size() >= `ISSUE_QUEUE_DEPTH - 1;
        exp_acc   = dec_valid & {2{~exp_full}};
        full_seen = full_seen | exp_full;
        k = 0;
        while (k < 2 && k < model_q.size()) begin
            pick[k] = model_q[k];
            k++;
        end
        for (int s = 1; s >= 0; s--) begin
            if (k < 2 && exp_acc[s]) begin
                pick[k] = make_entry(s);
                k++;
            end
        end
        // pick[0] is the older one and leaves on slot 1
        for (int i = 0; i < 2; i++) begin
            a = resolve(pick[i].ra1, pick[i].rd1);
            b = resolve(pick[i].ra2, pick[i].rd2);
            rdy[i]            = a[`DATA_W] & b[`DATA_W];
            exp_pc[1-i]       = pick[i].pc;
            exp_rd1[1-i]      = a[`DATA_W-1:0];
            exp_rd2[1-i]      = b[`DATA_W-1:0];
            exp_op[1-i]       = pick[i].op;
            exp_rdst[1-i]     = pick[i].rdst;
            exp_regwrite[1-i] = pick[i].regwrite;
            exp_imm[1-i]      = pick[i].imm;
            exp_is_slot[1-i]  = pick[i].is_slot;
        end
        hazard = (pick[0].regwrite && pick[0].rdst != '0 &&
                  (pick[0].rdst == pick[1].ra1 || pick[0].rdst == pick[1].ra2)) ||
                 (uses_muldiv_unit(pick[0].op) && uses_muldiv_unit(pick[1].op)) ||
                 (pick[0].op == issue_pkg::op_mtc0 && pick[1].op == issue_pkg::op_mtc0) ||
                 (pick[1].op inside {issue_pkg::op_branch, issue_pkg::op_jump});
        en1 = pick[0].valid && rdy[0];
        en0 = en1 && pick[1].valid && rdy[1] && (pick[1].is_slot || !hazard);
        exp_valid = {en1, en0} & {2{~flush}};
    endtask

    // one clock, inputs already set at the falling edge
    task automatic tick();
        int n;
        compute_expected();
        @(posedge clk);
        seen_iss = iss_valid;
        n = exp_valid[1] + exp_valid[0];
        if (flush) begin
            model_q.delete();
        end else begin
            for (int s = 1; s >= 0; s--) begin
                if (exp_acc[s]) begin
                    model_q.push_back(make_entry(s));
                end
            end
            repeat (n) begin
                void'(model_q.pop_front());
            end
        end
        @(negedge clk);
    endtask

    task automatic idle_decode();
        dec_valid   = '0;
        dec_is_slot = '0;
    endtask

    // register values derived from the pc
    task automatic put_slot(input int s, input issue_pkg::op_t op,
                            input logic [`REG_ADDR_W-1:0] rdst,
                            input logic [`REG_ADDR_W-1:0] ra1,
                            input logic [`REG_ADDR_W-1:0] ra2);
        dec_valid[s]    = 1'b1;
        dec_pc[s]       = next_pc;
        dec_op[s]       = op;
        dec_rdst[s]     = rdst;
        dec_regwrite[s] = 1'b1;
        dec_ra1[s]      = ra1;
        dec_ra2[s]      = ra2;
        dec_rd1[s]      = {next_pc[15:0], 16'h00a1};
        dec_rd2[s]      = {next_pc[15:0], 16'h00b2};
        dec_imm[s]      = next_pc ^ 32'h0000_ffff;
        dec_is_slot[s]  = 1'b0;
        next_pc         = next_pc + 32'd4;
    endtask

    task automatic put_random_slot(input int s);
        int r;
        r = $random(seed);
        put_slot(s, issue_pkg::op_t'(r[11:8] % 4'd9), {2'b00, r[14:12]},
                 {2'b00, r[17:15]}, {2'b00, r[20:18]});
        dec_rd1[s]      = $random(seed);
        dec_rd2[s]      = $random(seed);
        dec_regwrite[s] = r[23];
        dec_is_slot[s]  = (s == 0) && r[21] && r[22];
    endtask

    task automatic drain();
        int n;
        idle_decode();
        n = 0;
        while (model_q.size() != 0 && n < TMO) begin
            tick();
            n++;
        end
        if (model_q.size() != 0) begin
            fail_run("queued instructions did not drain before the timeout");
        end
    endtask

    task automatic run_pair(input issue_pkg::op_t op1, input logic [`REG_ADDR_W-1:0] rdst1,
                            input issue_pkg::op_t op0, input logic [`REG_ADDR_W-1:0] ra1_0,
                            input logic slot0);
        put_slot(1, op1, rdst1, 5'd1, 5'd2);
        put_slot(0, op0, 5'd8, ra1_0, 5'd3);
        dec_is_slot[0] = slot0;
        tick();
        drain();
    endtask

    task automatic wait_issue();
        int n;
        n = 0;
        seen_iss = '0;
        while (!seen_iss[1] && n < TMO) begin
            tick();
            n++;
        end
        if (!seen_iss[1]) begin
            fail_run("stalled instruction never issued after fwd_ready rose");
        end
    endtask

    initial begin
        int n;
        int r;
        seed      = 39089;
        clk       = 1'b0;
        arst_n    = 1'b0;
        flush     = 1'b0;
        dec_valid = '0;
        dec_pc    = '0;
        dec_op    = {issue_pkg::op_alu, issue_pkg::op_alu};
        dec_rdst  = '0;
        dec_regwrite = '0;
        dec_ra1   = '0;
        dec_ra2   = '0;
        dec_rd1   = '0;
        dec_rd2   = '0;
        dec_imm   = '0;
        dec_is_slot = '0;
        fwd_valid = '0;
        fwd_reg   = '0;
        fwd_ready = '0;
        fwd_data  = '0;
        exp_valid = '0;
        exp_pc    = '0;
        exp_rd1   = '0;
        exp_rd2   = '0;
        exp_op    = {issue_pkg::op_alu, issue_pkg::op_alu};
        exp_rdst  = '0;
        exp_regwrite = '0;
        exp_imm   = '0;
        exp_is_slot = '0;
        exp_full  = 1'b0;
        exp_acc   = '0;
        seen_iss  = '0;
        full_seen = 1'b0;
        next_pc   = 32'h0000_1000;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        // pass-through, RAW inside the pair, and RAW through $0
        run_pair(issue_pkg::op_alu, 5'd3, issue_pkg::op_alu, 5'd5, 1'b0);
        run_pair(issue_pkg::op_alu, 5'd7, issue_pkg::op_alu, 5'd7, 1'b0);
        run_pair(issue_pkg::op_alu, 5'd0, issue_pkg::op_alu, 5'd0, 1'b0);

        // execute and memory both hold $9, execute wins
        fwd_valid = 2'b11;
        fwd_reg   = {5'd9, 5'd9};
        fwd_ready = 2'b11;
        fwd_data  = {32'he0e0_0001, 32'hd0d0_0002};
        put_slot(1, issue_pkg::op_alu, 5'd10, 5'd9, 5'd1);
        put_slot(0, issue_pkg::op_alu, 5'd11, 5'd2, 5'd9);
        tick();
        fwd_reg[1] = 5'd12;
        put_slot(1, issue_pkg::op_alu, 5'd13, 5'd9, 5'd12);
        put_slot(0, issue_pkg::op_alu, 5'd14, 5'd12, 5'd3);
        tick();

        // pending execute result stalls the pair
        fwd_ready[1] = 1'b0;
        put_slot(1, issue_pkg::op_alu, 5'd15, 5'd12, 5'd1);
        put_slot(0, issue_pkg::op_alu, 5'd16, 5'd2, 5'd3);
        tick();
        idle_decode();
        repeat (3) tick();
        fwd_ready[1] = 1'b1;
        wait_issue();
        fwd_valid = '0;
        drain();

        // pairing exceptions
        run_pair(issue_pkg::op_mult, 5'd4, issue_pkg::op_mult, 5'd5, 1'b0);
        run_pair(issue_pkg::op_mtc0, 5'd0, issue_pkg::op_mtc0, 5'd5, 1'b0);
        run_pair(issue_pkg::op_alu, 5'd4, issue_pkg::op_branch, 5'd5, 1'b0);
        run_pair(issue_pkg::op_branch, 5'd31, issue_pkg::op_alu, 5'd31, 1'b1);

        // head waits on $1 while the queue fills, first entry alone
        fwd_valid = 2'b10;
        fwd_reg   = {5'd1, 5'd0};
        fwd_ready = 2'b00;
        n = 0;
        while (!full_seen && n < TMO) begin
            idle_decode();
            if (!queue_full) begin
                put_slot(1, issue_pkg::op_alu, 5'd2, 5'd1, 5'd0);
                if (n != 0) begin
                    put_slot(0, issue_pkg::op_alu, 5'd3, 5'd4, 5'd5);
                end
            end
            tick();
            n++;
        end
        if (!full_seen) begin
            fail_run("queue_full never rose while the head was stalled");
        end

        // random producers, decode and rare flushes
        for (int c = 0; c < 400; c++) begin
            idle_decode();
            r          = $random(seed);
            fwd_valid  = r[1:0];
            fwd_ready  = r[3:2] | {1'b0, r[4]};
            flush      = (r[10:5] == 6'd0);
            fwd_reg[1] = 5'd1 + {$random(seed)} % 6;
            fwd_reg[0] = 5'd1 + {$random(seed)} % 6;
            fwd_data   = {$random(seed), $random(seed)};
            if (!queue_full && r[11]) begin
                put_random_slot(1);
                if (r[12]) begin
                    put_random_slot(0);
                end
            end
            tick();
        end
        flush     = 1'b0;
        fwd_valid = '0;
        drain();

        // flush drops the queue and the pair offered with it
        fwd_valid = 2'b10;
        fwd_reg   = {5'd1, 5'd0};
        fwd_ready = 2'b00;
        put_slot(1, issue_pkg::op_alu, 5'd2, 5'd1, 5'd0);
        put_slot(0, issue_pkg::op_alu, 5'd3, 5'd4, 5'd5);
        tick();
        put_slot(1, issue_pkg::op_alu, 5'd6, 5'd7, 5'd0);
        put_slot(0, issue_pkg::op_alu, 5'd8, 5'd9, 5'd10);
        tick();
        flush = 1'b1;
        put_slot(1, issue_pkg::op_alu, 5'd11, 5'd1, 5'd2);
        put_slot(0, issue_pkg::op_alu, 5'd12, 5'd3, 5'd4);
        tick();
        flush = 1'b0;
        idle_decode();
        // producer gone, so the new pair passes straight through
        fwd_valid = '0;
        put_slot(1, issue_pkg::op_alu, 5'd13, 5'd1, 5'd2);
        put_slot(0, issue_pkg::op_alu, 5'd14, 5'd3, 5'd4);
        tick();
        drain();

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+rtl
rtl/issue_pkg.sv
rtl/operand_bypass.sv
rtl/pair_check.sv
rtl/issue_queue.sv
rtl/issue_stage.sv
bench/issue_stage_tb.sv

// ==== Bender.yml ====
package:
  name: issue_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/issue_pkg.sv
      - rtl/operand_bypass.sv
      - rtl/pair_check.sv
      - rtl/issue_queue.sv
      - rtl/issue_stage.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/issue_stage_tb.sv
